/* io_pkg.sv */
////////////////////////////////////////////////////////////
// Shared types for the memory-mapped I/O block. Imported
// by every I/O module and by the testbench.
////////////////////////////////////////////////////////////

package io_pkg;

	// Processor bus widths
	parameter int ADDR_W = 32;
	parameter int DATA_W = 32;

	// Seven-segment control after reset
	// Digits 3..0 enabled, decimal points off
	parameter logic [7:0] SEG_CTRL_RESET = 8'h0F;

	////////////////////////////////////////////////////////////
	// Register map, word index inside the 256-byte window
	////////////////////////////////////////////////////////////
	typedef enum logic [3:0] {
		REG_LED      = 4'd0,
		REG_SW       = 4'd1,
		REG_SEG_DATA = 4'd6,
		REG_SEG_CTRL = 4'd7,
		REG_BTN      = 4'd9,
		REG_TIMER    = 4'd12
	} io_reg_e;

	// Request from the memory stage
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic              wr;
		logic              rd;
	} io_req_t;

	// Decoded command, flags only set inside the window
	typedef struct packed {
		io_reg_e           sel;
		logic              wr;
		logic              rd;
		logic [DATA_W-1:0] data;
	} io_cmd_t;

	// Registered read response
	typedef struct packed {
		logic [DATA_W-1:0] rdata;
		logic              valid;
	} io_rsp_t;

	// Push buttons, MSB first
	typedef struct packed {
		logic up;
		logic right;
		logic down;
		logic left;
		logic centre;
	} btn_t;

endpackage

/* io_decode.sv */
////////////////////////////////////////////////////////////
// Address decoder for the I/O window. Turns a bus request
// into a register command in the same cycle.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module io_decode import io_pkg::*; #(
	parameter logic [ADDR_W-1:0] IO_BASE_ADDR = 32'h00007F00
) (
	input  io_req_t req_i,
	output io_cmd_t cmd_o
);

	// 256-byte window, upper bits must match the base
	localparam int WIN_BITS = 8;

	logic in_window;

	////////////////////////////////////////////////////////////
	// Window match
	////////////////////////////////////////////////////////////
	assign in_window = (req_i.addr[ADDR_W-1:WIN_BITS] == IO_BASE_ADDR[ADDR_W-1:WIN_BITS]);

	////////////////////////////////////////////////////////////
	// Command build
	////////////////////////////////////////////////////////////
	always_comb begin
		// Word index, byte offset dropped
		cmd_o.sel  = io_reg_e'(req_i.addr[5:2]);
		// Strobes only count inside the window
		cmd_o.wr   = in_window & req_i.wr;
		cmd_o.rd   = in_window & req_i.rd;
		// Write data goes straight through
		cmd_o.data = req_i.wdata;
	end

endmodule

/* io_input_sync.sv */
////////////////////////////////////////////////////////////
// Two-flop synchronizers for switch and button pins
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module io_input_sync import io_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic [15:0] sw_i,
	input  btn_t        btn_i,
	output logic [15:0] sw_o,
	output btn_t        btn_o
);

	// First stage may go metastable
	logic [15:0] sw_meta;
	btn_t        btn_meta;
	// Second stage is safe to use
	logic [15:0] sw_sync;
	btn_t        btn_sync;

	always_ff @(posedge clk) begin
		if (rst) begin
			sw_meta  <= '0;
			btn_meta <= '0;
			sw_sync  <= '0;
			btn_sync <= '0;
		end else begin
			sw_meta  <= sw_i;
			btn_meta <= btn_i;
			sw_sync  <= sw_meta;
			btn_sync <= btn_meta;
		end
	end

	// Pin change visible after two edges
	assign sw_o  = sw_sync;
	assign btn_o = btn_sync;

endmodule

/* io_ms_timer.sv */
////////////////////////////////////////////////////////////
// Free-running millisecond counter with software load
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module io_ms_timer import io_pkg::*; #(
	parameter int TIMER_CLOCKS_PER_MS = 33333
) (
	input  logic              clk,
	input  logic              rst,
	input  io_cmd_t           cmd_i,
	output logic [DATA_W-1:0] count_o
);

	// Prescaler sized to hold TIMER_CLOCKS_PER_MS-1
	localparam int              PRE_W    = $clog2(TIMER_CLOCKS_PER_MS + 1);
	localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(TIMER_CLOCKS_PER_MS - 1);

	logic [PRE_W-1:0]  pre_q;
	logic [DATA_W-1:0] count_q;
	logic              load;

	// Software write to the timer word
	assign load = cmd_i.wr && (cmd_i.sel == REG_TIMER);

	always_ff @(posedge clk) begin
		if (rst) begin
			pre_q   <= '0;
			count_q <= '0;
		end else if (load) begin
			// Load wins over a tick in the same cycle
			count_q <= cmd_i.data;
			pre_q   <= '0;
		end else if (pre_q == PRE_LAST) begin
			// One millisecond elapsed
			pre_q   <= '0;
			count_q <= count_q + 1'b1;
		end else begin
			pre_q <= pre_q + 1'b1;
		end
	end

	assign count_o = count_q;

endmodule

/* io_out_regs.sv */
////////////////////////////////////////////////////////////
// Writable output registers, LEDs and seven-segment data
// and control. Values go straight to the output ports.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module io_out_regs import io_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  io_cmd_t     cmd_i,
	output logic [15:0] led_o,
	output logic [15:0] seg_data_o,
	output logic [7:0]  seg_ctrl_o
);

	logic [15:0] led_q;
	logic [15:0] seg_data_q;
	logic [7:0]  seg_ctrl_q;

	// Per-register write enables
	logic led_we;
	logic seg_data_we;
	logic seg_ctrl_we;

	assign led_we      = cmd_i.wr && (cmd_i.sel == REG_LED);
	assign seg_data_we = cmd_i.wr && (cmd_i.sel == REG_SEG_DATA);
	assign seg_ctrl_we = cmd_i.wr && (cmd_i.sel == REG_SEG_CTRL);

	////////////////////////////////////////////////////////////
	// Registers, low bits of write data only
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			led_q      <= '0;
			seg_data_q <= '0;
			// Digits on, decimal points off
			seg_ctrl_q <= SEG_CTRL_RESET;
		end else begin
			if (led_we)
				led_q <= cmd_i.data[15:0];
			if (seg_data_we)
				seg_data_q <= cmd_i.data[15:0];
			// Bits 3..0 digit enable, 7..4 decimal points
			if (seg_ctrl_we)
				seg_ctrl_q <= cmd_i.data[7:0];
		end
	end

	assign led_o      = led_q;
	assign seg_data_o = seg_data_q;
	assign seg_ctrl_o = seg_ctrl_q;

endmodule

/* io_read_result.sv */
////////////////////////////////////////////////////////////
// Registered read mux. Response is valid the cycle after a
// read command, one response per read.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module io_read_result import io_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  io_cmd_t           cmd_i,
	input  logic [15:0]       led_i,
	input  logic [15:0]       sw_i,
	input  logic [15:0]       seg_data_i,
	input  logic [7:0]        seg_ctrl_i,
	input  btn_t              btn_i,
	input  logic [DATA_W-1:0] timer_i,
	output io_rsp_t           rsp_o
);

	logic [DATA_W-1:0] rd_mux;
	io_rsp_t           rsp_q;

	////////////////////////////////////////////////////////////
	// Select, zero-extended to the bus width
	////////////////////////////////////////////////////////////
	always_comb begin
		case (cmd_i.sel)
			REG_LED:      rd_mux = {{(DATA_W-16){1'b0}}, led_i};
			REG_SW:       rd_mux = {{(DATA_W-16){1'b0}}, sw_i};
			REG_SEG_DATA: rd_mux = {{(DATA_W-16){1'b0}}, seg_data_i};
			REG_SEG_CTRL: rd_mux = {{(DATA_W-8){1'b0}}, seg_ctrl_i};
			REG_BTN:      rd_mux = {{(DATA_W-$bits(btn_t)){1'b0}}, btn_i};
			REG_TIMER:    rd_mux = timer_i;
			// Unmapped words read as zero
			default:      rd_mux = '0;
		endcase
	end

	// Capture on read, value from before the edge
	always_ff @(posedge clk) begin
		if (rst) begin
			rsp_q <= '0;
		end else begin
			rsp_q.valid <= cmd_i.rd;
			if (cmd_i.rd)
				rsp_q.rdata <= rd_mux;
		end
	end

	assign rsp_o = rsp_q;

endmodule

/* io_system.sv */
////////////////////////////////////////////////////////////
// Top of the I/O block. Connect the memory stage request
// and the board pins; set the window base and clock rate.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module io_system import io_pkg::*; #(
	parameter logic [ADDR_W-1:0] IO_BASE_ADDR        = 32'h00007F00,
	parameter int                TIMER_CLOCKS_PER_MS = 33333
) (
	input  logic        clk,
	input  logic        rst,
	input  io_req_t     req_i,
	input  logic [15:0] sw_i,
	input  btn_t        btn_i,
	output io_rsp_t     rsp_o,
	output logic [15:0] led_o,
	output logic [16-1:0] seg_data_o,
	output logic [7:0]  seg_ctrl_o
);

	// Decoded command, shared by all devices
	io_cmd_t           cmd;
	// Synchronized pins
	logic [15:0]       sw_sync;
	btn_t              btn_sync;
	// Millisecond count
	logic [DATA_W-1:0] timer_count;

	////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////
	io_decode #(
		.IO_BASE_ADDR(IO_BASE_ADDR)
	) u_decode (
		.req_i(req_i),
		.cmd_o(cmd)
	);

	////////////////////////////////////////////////////////////
	// Devices
	////////////////////////////////////////////////////////////
	io_input_sync u_input_sync (
		.clk  (clk),
		.rst  (rst),
		.sw_i (sw_i),
		.btn_i(btn_i),
		.sw_o (sw_sync),
		.btn_o(btn_sync)
	);

	io_ms_timer #(
		.TIMER_CLOCKS_PER_MS(TIMER_CLOCKS_PER_MS)
	) u_ms_timer (
		.clk    (clk),
		.rst    (rst),
		.cmd_i  (cmd),
		.count_o(timer_count)
	);

	io_out_regs u_out_regs (
		.clk       (clk),
		.rst       (rst),
		.cmd_i     (cmd),
		.led_o     (led_o),
		.seg_data_o(seg_data_o),
		.seg_ctrl_o(seg_ctrl_o)
	);

	////////////////////////////////////////////////////////////
	// Result, reads back the live port values
	////////////////////////////////////////////////////////////
	io_read_result u_read_result (
		.clk       (clk),
		.rst       (rst),
		.cmd_i     (cmd),
		.led_i     (led_o),
		.sw_i      (sw_sync),
		.seg_data_i(seg_data_o),
		.seg_ctrl_i(seg_ctrl_o),
		.btn_i     (btn_sync),
		.timer_i   (timer_count),
		.rsp_o     (rsp_o)
	);

endmodule

/* io_system_tb.sv */
////////////////////////////////////////////////////////////
// Self-checking testbench for the I/O block. Runs the
// operation list from the stimulus file in order.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module io_system_tb import io_pkg::*; ();

	localparam logic [31:0] IO_BASE       = 32'h00007F00;
	localparam logic [31:0] TIMER_ADDR    = IO_BASE | {26'h0, REG_TIMER, 2'b00};
	localparam logic [31:0] SEG_DATA_ADDR = IO_BASE | {26'h0, REG_SEG_DATA, 2'b00};
	localparam int          STIM_DEPTH    = 64;
	localparam int          RSP_WAIT      = 10;

	// Operation codes of the stimulus file
	localparam logic [3:0] OP_IDLE        = 4'h0;
	localparam logic [3:0] OP_WRITE       = 4'h1;
	localparam logic [3:0] OP_READ        = 4'h2;
	localparam logic [3:0] OP_PINS        = 4'h3;
	localparam logic [3:0] OP_LED         = 4'h4;
	localparam logic [3:0] OP_SEG_CTRL    = 4'h5;
	localparam logic [3:0] OP_OUTSIDE     = 4'h6;
	localparam logic [3:0] OP_TIMER_RANGE = 4'h7;
	localparam logic [3:0] OP_RAND_WRITE  = 4'h8;
	localparam logic [3:0] OP_RAND_READ   = 4'h9;
	localparam logic [3:0] OP_RAND_LED    = 4'hA;
	localparam logic [3:0] OP_READ_PAIR   = 4'hB;
	localparam logic [3:0] OP_TIMER_LOAD  = 4'hC;
	localparam logic [3:0] OP_END         = 4'hF;

	logic        clk;
	logic        rst;
	io_req_t     req;
	logic [15:0] sw;
	btn_t        btn;
	io_rsp_t     rsp;
	logic [15:0] led;
	logic [15:0] seg_data;
	logic [7:0]  seg_ctrl;

	// Columns are test id, op, address, data and expected
	logic [103:0] stim_mem [0:STIM_DEPTH-1];
	integer       seed;
	logic [31:0]  rand_word;
	logic [31:0]  last_timer;
	int           errors;
	int           test_errors;
	int           tests_run;
	int           tests_failed;
	bit           timed_out;

	io_system #(
		.IO_BASE_ADDR       (IO_BASE),
		.TIMER_CLOCKS_PER_MS(4)
	) UUT (
		.clk       (clk),
		.rst       (rst),
		.req_i     (req),
		.sw_i      (sw),
		.btn_i     (btn),
		.rsp_o     (rsp),
		.led_o     (led),
		.seg_data_o(seg_data),
		.seg_ctrl_o(seg_ctrl)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////
	task automatic note_error();
		errors++;
		test_errors++;
	endtask

	task automatic check_rdata(input io_rsp_t r, input logic [DATA_W-1:0] exp);
		if (r.rdata !== exp) begin
			$display("FAIL rsp_o.rdata expected %h actual %h", exp, r.rdata);
			note_error();
		end
	endtask

	task automatic check_led(input logic [15:0] act, input logic [15:0] exp);
		if (act !== exp) begin
			$display("FAIL led_o expected %h actual %h", exp, act);
			note_error();
		end
	endtask

	task automatic check_seg_data(input logic [15:0] act, input logic [15:0] exp);
		if (act !== exp) begin
			$display("FAIL seg_data_o expected %h actual %h", exp, act);
			note_error();
		end
	endtask

	task automatic check_seg_ctrl(input logic [7:0] act, input logic [7:0] exp);
		if (act !== exp) begin
			$display("FAIL seg_ctrl_o expected %h actual %h", exp, act);
			note_error();
		end
	endtask

	// Timer only known to lie between the last read and a bound
	task automatic check_timer_range(input io_rsp_t r, input logic [31:0] lo,
			input logic [31:0] hi);
		if (r.rdata < lo || r.rdata > hi) begin
			$display("FAIL rsp_o.rdata expected %h to %h actual %h", lo, hi, r.rdata);
			note_error();
		end
	endtask

	task automatic end_test(input int id);
		tests_run++;
		if (test_errors == 0) begin
			$display("Test %0d passed", id);
		end else begin
			tests_failed++;
			$display("Test %0d failed with %0d error(s)", id, test_errors);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Bus operations start and end on a falling edge
	////////////////////////////////////////////////////////////
	task automatic do_write(input logic [31:0] addr, input logic [31:0] data);
		req = '{addr: addr, wdata: data, wr: 1'b1, rd: 1'b0};
		@(negedge clk);
		req.wr = 1'b0;
	endtask

	task automatic do_read(input logic [31:0] addr, output io_rsp_t r);
		int  n;
		bit  got;
		req = '{addr: addr, wdata: '0, wr: 1'b0, rd: 1'b1};
		@(negedge clk);
		req.rd = 1'b0;
		got = 1'b0;
		n = 0;
		r = '0;
		while (!got && n < RSP_WAIT) begin
			if (rsp.valid) begin
				got = 1'b1;
				r = rsp;
			end else begin
				@(negedge clk);
				n++;
			end
		end
		if (!got) begin
			$display("Timeout: no read response for address %h within %0d cycles",
				addr, RSP_WAIT);
			note_error();
			timed_out = 1'b1;
		end
	endtask

	// Outside read must give no response within 3 cycles
	task automatic read_outside(input logic [31:0] addr);
		int n;
		bit seen;
		req = '{addr: addr, wdata: '0, wr: 1'b0, rd: 1'b1};
		@(negedge clk);
		req.rd = 1'b0;
		seen = 1'b0;
		for (n = 0; n < 3; n++) begin
			if (rsp.valid)
				seen = 1'b1;
			@(negedge clk);
		end
		if (seen) begin
			$display("Read at %h outside the I/O window gave a response", addr);
			note_error();
		end
	endtask

	// Two reads on consecutive cycles give responses in order
	task automatic read_pair(input logic [31:0] a1, input logic [31:0] a2,
			input logic [31:0] exp);
		req = '{addr: a1, wdata: '0, wr: 1'b0, rd: 1'b1};
		@(negedge clk);
		req.addr = a2;
		if (!rsp.valid) begin
			$display("First back-to-back read gave no response in the next cycle");
			note_error();
		end else begin
			check_rdata(rsp, {16'h0, exp[31:16]});
		end
		@(negedge clk);
		req.rd = 1'b0;
		if (!rsp.valid) begin
			$display("Second back-to-back read gave no response in the next cycle");
			note_error();
		end else begin
			check_rdata(rsp, {16'h0, exp[15:0]});
		end
		// Valid drops once both responses are out
		@(negedge clk);
		if (rsp.valid) begin
			$display("Valid stayed high after the two back-to-back responses");
			note_error();
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////
	initial begin
		logic [103:0] entry;
		logic [3:0]   test_id;
		logic [3:0]   op;
		logic [31:0]  addr;
		logic [31:0]  data;
		logic [31:0]  exp;
		int           cur_test;
		int           idx;
		io_rsp_t      r;
		rst = 1'b1;
		req = '0;
		sw = '0;
		btn = '0;
		seed = 64502;
		rand_word = '0;
		last_timer = '0;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		// Fill with end markers that carry the index in the low bits
		for (idx = 0; idx < STIM_DEPTH; idx++)
			stim_mem[idx] = {4'h0, OP_END, 64'h0, 32'(idx)};
		$readmemh("io_system_stimulus.txt", stim_mem);
		repeat (5) @(negedge clk);
		rst = 1'b0;
		cur_test = 0;
		idx = 0;
		while (idx < STIM_DEPTH && !timed_out) begin
			entry = stim_mem[idx];
			{test_id, op, addr, data, exp} = entry;
			if (op == OP_END)
				break;
			if (test_id != cur_test) begin
				if (cur_test != 0)
					end_test(cur_test);
				cur_test = test_id;
				test_errors = 0;
			end
			case (op)
				OP_IDLE:     repeat (data) @(negedge clk);
				OP_WRITE:    do_write(addr, data);
				OP_LED:      check_led(led, exp[15:0]);
				OP_SEG_CTRL: check_seg_ctrl(seg_ctrl, exp[7:0]);
				OP_OUTSIDE:  read_outside(addr);
				OP_READ_PAIR: read_pair(addr, data, exp);
				OP_RAND_LED: check_led(led, rand_word[15:0] & exp[15:0]);
				OP_READ: begin
					do_read(addr, r);
					if (!timed_out)
						check_rdata(r, exp);
					// Data port shows the same value as the read back
					if (addr == SEG_DATA_ADDR)
						check_seg_data(seg_data, exp[15:0]);
				end
				OP_PINS: begin
					sw = data[15:0];
					btn = data[20:16];
					@(negedge clk);
				end
				OP_TIMER_RANGE: begin
					do_read(addr, r);
					if (!timed_out) begin
						check_timer_range(r, last_timer, exp);
						last_timer = r.rdata;
					end
				end
				OP_RAND_WRITE: begin
					rand_word = $random(seed);
					do_write(addr, rand_word);
				end
				OP_RAND_READ: begin
					do_read(addr, r);
					if (!timed_out)
						check_rdata(r, rand_word & exp);
				end
				OP_TIMER_LOAD: begin
					// Address column is the gap between load and read
					do_write(TIMER_ADDR, data);
					repeat (addr) @(negedge clk);
					do_read(TIMER_ADDR, r);
					if (!timed_out)
						check_rdata(r, exp);
				end
				default: begin
					$display("Unknown operation %h at stimulus entry %0d", op, idx);
					note_error();
				end
			endcase
			idx++;
		end
		if (cur_test != 0)
			end_test(cur_test);
		$display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (errors == 0 && !timed_out)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* io_system.f */
io_pkg.sv
io_decode.sv
io_input_sync.sv
io_ms_timer.sv
io_out_regs.sv
io_read_result.sv
io_system.sv
io_system_tb.sv

/* io_system_stimulus.txt */
// Columns: test _ op _ address _ data _ expected, all hex, one operation per line
// Ops: 0 idle, 1 write, 2 read, 3 pins, 4 led port, 5 seg ctrl port, 6 outside read,
// 7 timer range, 8 random write, 9 random read, A random led port, B read pair,
// C timer load and read (address = cycles between), F end
// Test 1, reset values
1_2_00007F1C_00000000_0000000F
1_4_00000000_00000000_00000000
1_7_00007F30_00000000_00000010
1_0_00000000_00000002_00000000
1_7_00007F30_00000000_00000010
// Test 2, write then read back
2_8_00007F00_00000000_00000000
2_A_00000000_00000000_0000FFFF
2_9_00007F00_00000000_0000FFFF
2_1_00007F00_1234ABCD_00000000
2_4_00000000_00000000_0000ABCD
2_2_00007F00_00000000_0000ABCD
2_1_00007F18_CAFE5678_00000000
2_2_00007F18_00000000_00005678
2_1_00007F1C_DEADBE5A_00000000
2_5_00000000_00000000_0000005A
2_2_00007F1C_00000000_0000005A
// Test 3, pins, data holds btn in bits 20..16 and sw in 15..0
3_3_00000000_0016A5C3_00000000
3_0_00000000_00000003_00000000
3_2_00007F04_00000000_0000A5C3
3_2_00007F24_00000000_00000016
// Test 4, timer load, four clocks per tick
4_C_00000000_00000100_00000100
4_C_00000003_00000100_00000100
4_C_00000004_00000100_00000101
4_C_00000009_00000100_00000102
4_C_0000000D_00000100_00000103
// Test 5, outside the window and unmapped word
5_1_00007E00_0000FFFF_00000000
5_4_00000000_00000000_0000ABCD
5_6_00007E00_00000000_00000000
5_2_00007F0C_00000000_00000000
// Test 6, back-to-back reads of LED then seg data
6_B_00007F00_00007F18_ABCD5678
0_F_00000000_00000000_00000000
